/* logic/matrix_cfg_pkg.sv */
package matrix_cfg_pkg;

    // Matrix geometry
    localparam int MAT_DIM     = 4;
    localparam int BLOCK_WORDS = MAT_DIM * MAT_DIM;
    localparam int IDX_WIDTH   = $clog2(MAT_DIM);

    // RAM layout, one fixed block per slot
    localparam int NUM_SLOTS   = 8;
    localparam int ADDR_WIDTH  = 7;
    localparam int DATA_WIDTH  = 16;
    localparam int SCALAR_SLOT = 7;
    localparam int RESULT_SLOT = 6;

    // Result buffering
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_id_t;
    typedef logic [ADDR_WIDTH-1:0]        ram_addr_t;
    typedef logic [DATA_WIDTH-1:0]        elem_t;
    typedef logic [IDX_WIDTH-1:0]         idx_t;

endpackage

/* logic/matrix_cmd_pkg.sv */
package matrix_cmd_pkg;

    // -------------------------------------------------------------------------
    // Operation codes
    // -------------------------------------------------------------------------

    typedef enum logic [1:0] {
        CALC_ADD        = 2'd0,
        CALC_TRANSPOSE  = 2'd1,
        CALC_SCALAR_MUL = 2'd2
    } calc_type_t;

    // -------------------------------------------------------------------------
    // Command and write traffic
    // -------------------------------------------------------------------------

    // One command as issued by the host
    typedef struct packed {
        calc_type_t              op;
        matrix_cfg_pkg::slot_id_t src_a;
        // Only read by element-wise add
        matrix_cfg_pkg::slot_id_t src_b;
        matrix_cfg_pkg::elem_t    scalar;
    } exec_cmd_t;

    // One word headed for storage
    typedef struct packed {
        matrix_cfg_pkg::slot_id_t matrix_id;
        matrix_cfg_pkg::elem_t    data;
        // Final word of its block
        logic                     last;
    } write_item_t;

endpackage

/* logic/op_sequencer.sv */
`timescale 1ns/1ps

module op_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  matrix_cmd_pkg::exec_cmd_t cmd,
    output logic                      launch,
    output matrix_cmd_pkg::exec_cmd_t cmd_q,
    input  logic                      issue_done,
    input  logic                      block_done,
    output logic                      busy,
    output logic                      done
);

    // Running lasts until the engine has pushed its last item.
    // Finishing waits for that block to land in storage.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUNNING,
        ST_FINISHING
    } state_t;

    state_t state;

    // -------------------------------------------------------------------------
    // Control FSM
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            launch <= 1'b0;
            done   <= 1'b0;
        end else begin
            launch <= 1'b0;
            done   <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        launch <= 1'b1;
                        state  <= ST_RUNNING;
                    end
                end

                // Staging block_done of scalar multiply passes here unseen
                ST_RUNNING: begin
                    if (issue_done) begin
                        state <= ST_FINISHING;
                    end
                end

                ST_FINISHING: begin
                    if (block_done) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command held stable for the engine until the next idle start
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            cmd_q <= cmd;
        end
    end

    assign busy = (state != ST_IDLE);

endmodule

/* logic/element_engine.sv */
`timescale 1ns/1ps

module element_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        launch,
    input  matrix_cmd_pkg::exec_cmd_t   cmd_q,
    output matrix_cfg_pkg::ram_addr_t   read_addr,
    input  matrix_cfg_pkg::elem_t       read_data,
    output logic                        push,
    output matrix_cmd_pkg::write_item_t item,
    input  logic                        full,
    input  logic                        block_done,
    output logic                        issue_done
);

    import matrix_cfg_pkg::*;
    import matrix_cmd_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_STAGE_PUSH,
        ST_STAGE_WAIT,
        ST_SCALAR_RD,
        ST_SCALAR_CAP,
        ST_RD_A,
        ST_RD_B,
        ST_CALC,
        ST_PUSH
    } state_t;

    state_t state;

    // Output element position
    idx_t  row;
    idx_t  col;
    logic  last_elem;

    elem_t a_q;
    elem_t scalar_q;
    elem_t res_q;
    logic [2*DATA_WIDTH-1:0] product;

    // Offset of the source word inside its block
    ram_addr_t src_off;

    function automatic ram_addr_t slot_base(input slot_id_t slot);
        return ram_addr_t'(slot * BLOCK_WORDS);
    endfunction

    // -------------------------------------------------------------------------
    // Read addressing
    // -------------------------------------------------------------------------

    always_comb begin
        if (cmd_q.op == CALC_TRANSPOSE) begin
            src_off = ram_addr_t'(col * MAT_DIM + row);
        end else begin
            src_off = ram_addr_t'(row * MAT_DIM + col);
        end
    end

    always_comb begin
        case (state)
            ST_SCALAR_RD: read_addr = slot_base(slot_id_t'(SCALAR_SLOT));
            ST_RD_B:      read_addr = slot_base(cmd_q.src_b) + src_off;
            default:      read_addr = slot_base(cmd_q.src_a) + src_off;
        endcase
    end

    // -------------------------------------------------------------------------
    // Sequencing
    // -------------------------------------------------------------------------

    assign last_elem = (row == idx_t'(MAT_DIM - 1)) && (col == idx_t'(MAT_DIM - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            row   <= '0;
            col   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        row <= '0;
                        col <= '0;
                        if (cmd_q.op == CALC_SCALAR_MUL) begin
                            state <= ST_STAGE_PUSH;
                        end else begin
                            state <= ST_RD_A;
                        end
                    end
                end
                ST_STAGE_PUSH: begin
                    if (!full) begin
                        state <= ST_STAGE_WAIT;
                    end
                end
                // Scalar must be in storage before it is read back
                ST_STAGE_WAIT: begin
                    if (block_done) begin
                        state <= ST_SCALAR_RD;
                    end
                end
                ST_SCALAR_RD:  state <= ST_SCALAR_CAP;
                ST_SCALAR_CAP: state <= ST_RD_A;
                ST_RD_A: begin
                    if (cmd_q.op == CALC_ADD) begin
                        state <= ST_RD_B;
                    end else begin
                        state <= ST_CALC;
                    end
                end
                ST_RD_B: state <= ST_CALC;
                ST_CALC: state <= ST_PUSH;
                ST_PUSH: begin
                    if (!full) begin
                        if (last_elem) begin
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_RD_A;
                            if (col == idx_t'(MAT_DIM - 1)) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // Arithmetic
    // -------------------------------------------------------------------------

    // Full product of which only the low word is kept
    assign product = read_data * scalar_q;

    always_ff @(posedge clk) begin
        case (state)
            ST_SCALAR_CAP: scalar_q <= read_data;
            ST_RD_B:       a_q      <= read_data;
            ST_CALC: begin
                case (cmd_q.op)
                    CALC_ADD:        res_q <= a_q + read_data;
                    CALC_SCALAR_MUL: res_q <= product[DATA_WIDTH-1:0];
                    default:         res_q <= read_data;
                endcase
            end
            default: ;
        endcase
    end

    assign push       = ((state == ST_STAGE_PUSH) || (state == ST_PUSH)) && !full;
    assign issue_done = (state == ST_PUSH) && !full && last_elem;

    always_comb begin
        if (state == ST_STAGE_PUSH) begin
            item.matrix_id = slot_id_t'(SCALAR_SLOT);
            item.data      = cmd_q.scalar;
            item.last      = 1'b1;
        end else begin
            item.matrix_id = slot_id_t'(RESULT_SLOT);
            item.data      = res_q;
            item.last      = last_elem;
        end
    end

endmodule

/* logic/result_fifo.sv */
`timescale 1ns/1ps

module result_fifo (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  matrix_cmd_pkg::write_item_t wr_item,
    output logic                        full,
    input  logic                        pop,
    output matrix_cmd_pkg::write_item_t rd_item,
    output logic                        empty
);

    import matrix_cfg_pkg::*;
    import matrix_cmd_pkg::*;

    write_item_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;
    logic                      do_push;
    logic                      do_pop;

    function automatic logic [FIFO_PTR_WIDTH-1:0] ptr_next(
        input logic [FIFO_PTR_WIDTH-1:0] ptr
    );
        if (ptr == FIFO_PTR_WIDTH'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rd_item = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Simultaneous push and pop leaves the level alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_item;
        end
    end

endmodule

/* logic/block_writer.sv */
`timescale 1ns/1ps

module block_writer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  matrix_cmd_pkg::write_item_t rd_item,
    input  logic                        empty,
    output logic                        pop,
    output logic                        write_request,
    output matrix_cfg_pkg::slot_id_t    write_matrix_id,
    output matrix_cfg_pkg::elem_t       write_data,
    output logic                        write_data_valid,
    input  logic                        writer_ready,
    input  logic                        write_done,
    output logic                        block_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_STREAM,
        ST_WAIT_DONE
    } state_t;

    state_t state;

    // A word moves when storage is ready and the FIFO has one
    logic beat;

    assign beat             = (state == ST_STREAM) && writer_ready && !empty;
    assign pop              = beat;
    assign write_data_valid = beat;
    assign write_data       = rd_item.data;
    assign write_request    = (state == ST_REQUEST);

    // -------------------------------------------------------------------------
    // Storage handshake
    // -------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            block_done <= 1'b0;
        end else begin
            block_done <= 1'b0;

            case (state)
                // First item of a block opens the request
                ST_IDLE: begin
                    if (!empty) begin
                        state <= ST_REQUEST;
                    end
                end

                ST_REQUEST: begin
                    if (writer_ready) begin
                        state <= ST_STREAM;
                    end
                end

                ST_STREAM: begin
                    if (beat && rd_item.last) begin
                        state <= ST_WAIT_DONE;
                    end
                end

                ST_WAIT_DONE: begin
                    if (write_done) begin
                        block_done <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Slot id stays put for the whole block
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && !empty) begin
            write_matrix_id <= rd_item.matrix_id;
        end
    end

endmodule

/* logic/matrix_exec_top.sv */
`timescale 1ns/1ps

module matrix_exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  matrix_cmd_pkg::exec_cmd_t cmd,
    output logic                      busy,
    output logic                      done,
    output matrix_cfg_pkg::ram_addr_t read_addr,
    input  matrix_cfg_pkg::elem_t     read_data,
    output logic                      write_request,
    output matrix_cfg_pkg::slot_id_t  write_matrix_id,
    output matrix_cfg_pkg::elem_t     write_data,
    output logic                      write_data_valid,
    input  logic                      writer_ready,
    input  logic                      write_done
);

    import matrix_cmd_pkg::*;

    exec_cmd_t   cmd_q;
    logic        launch;
    logic        issue_done;
    logic        block_done;

    // Engine to FIFO to writer
    write_item_t push_item;
    write_item_t pop_item;
    logic        push;
    logic        full;
    logic        pop;
    logic        empty;

    op_sequencer u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cmd        (cmd),
        .launch     (launch),
        .cmd_q      (cmd_q),
        .issue_done (issue_done),
        .block_done (block_done),
        .busy       (busy),
        .done       (done)
    );

    element_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .launch     (launch),
        .cmd_q      (cmd_q),
        .read_addr  (read_addr),
        .read_data  (read_data),
        .push       (push),
        .item       (push_item),
        .full       (full),
        .block_done (block_done),
        .issue_done (issue_done)
    );

    result_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (push),
        .wr_item (push_item),
        .full    (full),
        .pop     (pop),
        .rd_item (pop_item),
        .empty   (empty)
    );

    block_writer u_writer (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_item          (pop_item),
        .empty            (empty),
        .pop              (pop),
        .write_request    (write_request),
        .write_matrix_id  (write_matrix_id),
        .write_data       (write_data),
        .write_data_valid (write_data_valid),
        .writer_ready     (writer_ready),
        .write_done       (write_done),
        .block_done       (block_done)
    );

endmodule

/* bench/storage_model.sv */
`timescale 1ns/1ps

module storage_model (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall_en,
    input  matrix_cfg_pkg::ram_addr_t read_addr,
    output matrix_cfg_pkg::elem_t     read_data,
    input  logic                      write_request,
    input  matrix_cfg_pkg::slot_id_t  write_matrix_id,
    input  matrix_cfg_pkg::elem_t     write_data,
    input  logic                      write_data_valid,
    output logic                      writer_ready,
    output logic                      write_done
);

    import matrix_cfg_pkg::*;
    import matrix_cmd_pkg::*;

    localparam int MEM_WORDS = NUM_SLOTS * BLOCK_WORDS;

    elem_t     mem [MEM_WORDS];
    ram_addr_t addr_q;
    slot_id_t  wr_slot;
    int        wr_idx;
    logic      done_pend;
    int        block_count;

    // Scalar staging blocks hold a single word
    function automatic int block_len(input slot_id_t slot);
        if (slot == slot_id_t'(SCALAR_SLOT)) begin
            return 1;
        end
        return BLOCK_WORDS;
    endfunction

    function automatic ram_addr_t word_addr(input slot_id_t slot, input int idx);
        return ram_addr_t'(int'(slot) * BLOCK_WORDS + idx);
    endfunction

    // ------------------------------------------------------------------------
    // Read addresses and write words taken on the rising edge
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[ram_addr_t'(i)] <= elem_t'($urandom);
            end
            addr_q      <= '0;
            wr_slot     <= '0;
            wr_idx      <= 0;
            done_pend   <= 1'b0;
            block_count <= 0;
        end else begin
            addr_q    <= read_addr;
            done_pend <= 1'b0;
            if (write_request && writer_ready) begin
                wr_slot <= write_matrix_id;
                wr_idx  <= 0;
            end
            if (write_data_valid) begin
                mem[word_addr(wr_slot, wr_idx)] <= write_data;
                wr_idx <= wr_idx + 1;
                if (wr_idx + 1 == block_len(wr_slot)) begin
                    done_pend   <= 1'b1;
                    block_count <= block_count + 1;
                end
            end
        end
    end

    // Outputs toward the DUT change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_data    <= '0;
            writer_ready <= 1'b0;
            write_done   <= 1'b0;
        end else begin
            read_data    <= mem[addr_q];
            write_done   <= done_pend;
            // Ready about one cycle in four under stall so the FIFO fills up
            writer_ready <= stall_en ? ($urandom_range(0, 3) == 0) : 1'b1;
        end
    end

endmodule

/* bench/matrix_exec_tb.sv */
`timescale 1ns/1ps

module matrix_exec_tb;

    import matrix_cfg_pkg::*;
    import matrix_cmd_pkg::*;

    localparam int          NUM_CMDS    = 40;
    localparam int          CYCLE_LIMIT = NUM_CMDS * 400;
    localparam int          STALL_CMDS  = 30;
    localparam logic [31:0] SEED        = 32'h8fda_dc9e;

    typedef elem_t [BLOCK_WORDS-1:0]        block_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0] widx_t;

    logic      clk;
    logic      rst_n;
    logic      start;
    exec_cmd_t cmd;
    logic      busy;
    logic      done;
    ram_addr_t read_addr;
    elem_t     read_data;
    logic      write_request;
    slot_id_t  write_matrix_id;
    elem_t     write_data;
    logic      write_data_valid;
    logic      writer_ready;
    logic      write_done;
    logic      stall_en;

    // Storage contents before the current command
    block_t snap [NUM_SLOTS];
    int     cycles     = 0;
    int     done_count = 0;

    matrix_exec_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .cmd              (cmd),
        .busy             (busy),
        .done             (done),
        .read_addr        (read_addr),
        .read_data        (read_data),
        .write_request    (write_request),
        .write_matrix_id  (write_matrix_id),
        .write_data       (write_data),
        .write_data_valid (write_data_valid),
        .writer_ready     (writer_ready),
        .write_done       (write_done)
    );

    storage_model store0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .stall_en         (stall_en),
        .read_addr        (read_addr),
        .read_data        (read_data),
        .write_request    (write_request),
        .write_matrix_id  (write_matrix_id),
        .write_data       (write_data),
        .write_data_valid (write_data_valid),
        .writer_ready     (writer_ready),
        .write_done       (write_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Done pulse count and the run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (done) begin
            done_count <= done_count + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            abort_run();
        end
    end

    // ------------------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------------------

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_status(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_block(input string name, input block_t got, input block_t exp);
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            if (got[widx_t'(i)] !== exp[widx_t'(i)]) begin
                $display("MISMATCH at %0t: %s[%0d] is %h, expected %h", $time, name, i,
                         got[widx_t'(i)], exp[widx_t'(i)]);
                abort_run();
            end
        end
    endtask

    task automatic expect_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("At %0t the command produced %0d %s, expected %0d", $time, got, what, exp);
            abort_run();
        end
    endtask

    function automatic block_t read_block(input slot_id_t slot);
        block_t b;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            b[widx_t'(i)] = store0.mem[ram_addr_t'(int'(slot) * BLOCK_WORDS + i)];
        end
        return b;
    endfunction

    task automatic take_snapshot();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            snap[slot_id_t'(s)] = read_block(slot_id_t'(s));
        end
    endtask

    // Expected result block worked out from the snapshot
    function automatic block_t expected_result(input exec_cmd_t c);
        block_t res;
        block_t a;
        block_t b;
        widx_t  o;
        widx_t  t;
        a = snap[c.src_a];
        b = snap[c.src_b];
        for (int r = 0; r < MAT_DIM; r++) begin
            for (int k = 0; k < MAT_DIM; k++) begin
                o = widx_t'(r * MAT_DIM + k);
                t = widx_t'(k * MAT_DIM + r);
                case (c.op)
                    CALC_ADD:       res[o] = a[o] + b[o];
                    CALC_TRANSPOSE: res[o] = a[t];
                    default:        res[o] = a[o] * c.scalar;
                endcase
            end
        end
        return res;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Sources stay clear of the result and scalar slots
    function automatic exec_cmd_t random_cmd(input calc_type_t op);
        exec_cmd_t c;
        c.op     = op;
        c.src_a  = slot_id_t'($urandom_range(0, RESULT_SLOT - 1));
        c.src_b  = slot_id_t'($urandom_range(0, RESULT_SLOT - 1));
        c.scalar = elem_t'($urandom);
        return c;
    endfunction

    // Called on a falling edge, returns on the falling edge after done
    task automatic run_command(input exec_cmd_t c, input bit poke_busy);
        block_t exp;
        block_t exp_scalar;
        int     done_before;
        int     blocks_before;
        int     wait_cycles;
        take_snapshot();
        exp           = expected_result(c);
        done_before   = done_count;
        blocks_before = store0.block_count;
        check_status("busy", busy, 1'b0);
        cmd   = c;
        start = 1'b1;
        @(negedge clk);
        start       = 1'b0;
        wait_cycles = 0;
        while (!done) begin
            check_status("busy", busy, 1'b1);
            // Second start while running must be dropped
            if (poke_busy && (wait_cycles == 3)) begin
                cmd   = random_cmd(CALC_TRANSPOSE);
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            wait_cycles++;
            @(negedge clk);
        end
        start = 1'b0;
        check_status("busy", busy, 1'b0);
        @(negedge clk);
        check_status("done", done, 1'b0);
        check_status("busy", busy, 1'b0);
        expect_count("done pulses", done_count - done_before, 1);
        expect_count("write blocks", store0.block_count - blocks_before,
                     (c.op == CALC_SCALAR_MUL) ? 2 : 1);

        check_block("result", read_block(slot_id_t'(RESULT_SLOT)), exp);
        if (c.op == CALC_ADD) begin
            check_block("src_a", read_block(c.src_a), snap[c.src_a]);
            check_block("src_b", read_block(c.src_b), snap[c.src_b]);
        end
        if (c.op == CALC_SCALAR_MUL) begin
            exp_scalar    = snap[slot_id_t'(SCALAR_SLOT)];
            exp_scalar[0] = c.scalar;
            check_block("scalar_slot", read_block(slot_id_t'(SCALAR_SLOT)), exp_scalar);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = '0;
        stall_en = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_status("busy", busy, 1'b0);
        check_status("done", done, 1'b0);
        check_status("write_request", write_request, 1'b0);
        check_status("write_data_valid", write_data_valid, 1'b0);

        // Directed commands with storage always ready
        run_command(random_cmd(CALC_ADD), 1'b0);
        run_command(random_cmd(CALC_TRANSPOSE), 1'b0);
        run_command(random_cmd(CALC_SCALAR_MUL), 1'b0);
        run_command(random_cmd(CALC_ADD), 1'b1);
        run_command(random_cmd(CALC_SCALAR_MUL), 1'b1);

        // Mixed commands against a stalling storage port
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        for (int n = 0; n < STALL_CMDS; n++) begin
            run_command(random_cmd(calc_type_t'($urandom_range(0, 2))), 1'b0);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* matrix_exec.f */
logic/matrix_cfg_pkg.sv
logic/matrix_cmd_pkg.sv
logic/op_sequencer.sv
logic/element_engine.sv
logic/result_fifo.sv
logic/block_writer.sv
logic/matrix_exec_top.sv
bench/storage_model.sv
bench/matrix_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the matrix_exec testbench with Verilator

LOG=sim.log

verilator --binary --timing --top-module matrix_exec_tb \
    -o matrix_exec_sim -f matrix_exec.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/matrix_exec_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation passed"
exit 0
